// File: hw/opn_clk_pkg.sv
package opn_clk_pkg;

    // bus field widths
    typedef logic [1:0] div_sel_t;   // prescaler select bits
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [9:0] timer_a_t;   // 10 bit load value
    typedef logic [7:0] timer_b_t;

    // register map
    localparam reg_addr_t ADDR_TA_HI   = 8'h24;  // timer a bits 9..2
    localparam reg_addr_t ADDR_TA_LO   = 8'h25;  // timer a bits 1..0
    localparam reg_addr_t ADDR_TB      = 8'h26;
    localparam reg_addr_t ADDR_TCTL    = 8'h27;  // load, enable, flag reset
    localparam reg_addr_t ADDR_PRES_2D = 8'h2d;
    localparam reg_addr_t ADDR_PRES_2E = 8'h2e;
    localparam reg_addr_t ADDR_PRES_2F = 8'h2f;

    localparam div_sel_t DIV_RESET = 2'b10;  // fm 1/6 and ssg 1/4
    localparam bit USE_SSG = 1'b1;           // ssg enable generated

    // divider ratios
    localparam int FM_PER_SAMPLE = 24;  // fm enables per sample
    localparam int TB_PRESCALE   = 16;  // samples per timer b step
    localparam int ADPCM_666_DIV = 12;
    localparam int ADPCM_111_DIV = 6;
    localparam int ADPCM_55_DIV  = 2;

    // counter widths derived from the ratios
    typedef logic [2:0] fm_cnt_t;   // up to 1/6
    typedef logic [1:0] ssg_cnt_t;  // up to 1/4
    typedef logic [$clog2(ADPCM_666_DIV)-1:0] a666_cnt_t;
    typedef logic [$clog2(ADPCM_111_DIV)-1:0] a111_cnt_t;
    typedef logic [$clog2(ADPCM_55_DIV)-1:0]  a55_cnt_t;
    typedef logic [$clog2(FM_PER_SAMPLE)-1:0] smp_cnt_t;
    typedef logic [$clog2(TB_PRESCALE)-1:0]   tbp_cnt_t;

    typedef struct packed {
        logic      wr;    // one cycle strobe
        reg_addr_t addr;
        reg_data_t data;
    } cpu_wr_t;

    typedef struct packed {
        logic fm;
        logic third;
        logic ssg;
        logic a666;
        logic a111;
        logic a55;
    } clk_ens_t;

    typedef struct packed {
        logic     load_a;      // timer a runs while high
        logic     load_b;
        logic     en_a;        // overflow may set flag a
        logic     en_b;
        logic     rst_flag_a;  // single cycle clear
        logic     rst_flag_b;
        timer_a_t val_a;
        timer_b_t val_b;
    } timer_cfg_t;

endpackage

// File: hw/opn_reg_if.sv
`timescale 1ns/10ps

module opn_reg_if
    import opn_clk_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cpu_wr_t    cpu_wr,
    output div_sel_t   div_sel,
    output timer_cfg_t timer_cfg
);

    logic pres_wr;  // any write that touches the prescaler
    logic tmr_wr;   // write to one of the timer registers

    assign pres_wr = cpu_wr.wr && (cpu_wr.addr inside {ADDR_PRES_2D, ADDR_PRES_2E,
                                                       ADDR_PRES_2F});
    assign tmr_wr  = cpu_wr.wr && (cpu_wr.addr inside {ADDR_TA_HI, ADDR_TA_LO, ADDR_TB,
                                                       ADDR_TCTL});

    // prescaler select
    // 2d and 2e set one bit each, 2f clears both
    // written data plays no part
    always_ff @(posedge clk) begin
        if (rst) begin
            div_sel <= DIV_RESET;
        end else if (pres_wr) begin
            case (cpu_wr.addr)
                ADDR_PRES_2D: div_sel <= div_sel | 2'b10;
                ADDR_PRES_2E: div_sel <= div_sel | 2'b01;
                default:      div_sel <= 2'b00;  // 2f
            endcase
        end
    end

    // timer registers
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_cfg <= '0;
        end else begin
            // flag resets last one cycle only
            timer_cfg.rst_flag_a <= 1'b0;
            timer_cfg.rst_flag_b <= 1'b0;
            if (tmr_wr) begin
                case (cpu_wr.addr)
                    ADDR_TA_HI: timer_cfg.val_a[9:2] <= cpu_wr.data;
                    ADDR_TA_LO: timer_cfg.val_a[1:0] <= cpu_wr.data[1:0];  // upper bits unused
                    ADDR_TB:    timer_cfg.val_b      <= cpu_wr.data;
                    default: begin
                        // control register 27
                        timer_cfg.load_a     <= cpu_wr.data[0];
                        timer_cfg.load_b     <= cpu_wr.data[1];
                        timer_cfg.en_a       <= cpu_wr.data[2];
                        timer_cfg.en_b       <= cpu_wr.data[3];
                        timer_cfg.rst_flag_a <= cpu_wr.data[4];  // pulse next cycle
                        timer_cfg.rst_flag_b <= cpu_wr.data[5];
                    end
                endcase
            end
        end
    end

endmodule

// File: hw/opn_clk_div.sv
`timescale 1ns/10ps

module opn_clk_div
    import opn_clk_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  div_sel_t div_sel,
    output clk_ens_t clk_ens
);

    fm_cnt_t   fm_pres, fm_pres_q, fm_cnt;     // terminal counts are period minus one
    ssg_cnt_t  ssg_pres, ssg_pres_q, ssg_cnt;
    logic [1:0] third_cnt;                     // fixed 1/3
    a666_cnt_t cnt666;
    a111_cnt_t cnt111;
    a55_cnt_t  cnt55;
    clk_ens_t  zero_q;                         // zero detect one stage ahead
    logic      cen_q;

    // select decode
    always_comb begin
        case (div_sel)
            2'b10: begin
                fm_pres  = 3'd5;  // fm 1/6
                ssg_pres = 2'd3;  // ssg 1/4
            end
            2'b11: begin
                fm_pres  = 3'd2;  // fm 1/3
                ssg_pres = 2'd1;  // ssg 1/2
            end
            default: begin
                fm_pres  = 3'd1;  // fm 1/2 for 00 and 01
                ssg_pres = 2'd0;  // ssg every cen
            end
        endcase
    end

    // fm, ssg and third counters
    // new select is picked up only at the wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            fm_cnt     <= '0;
            fm_pres_q  <= fm_pres;
            ssg_cnt    <= '0;
            ssg_pres_q <= ssg_pres;
            third_cnt  <= '0;
        end else if (cen) begin
            if (fm_cnt == fm_pres_q) begin
                fm_cnt    <= '0;
                fm_pres_q <= fm_pres;
            end else begin
                fm_cnt <= fm_cnt + 3'd1;
            end
            if (ssg_cnt == ssg_pres_q) begin
                ssg_cnt    <= '0;
                ssg_pres_q <= ssg_pres;
            end else begin
                ssg_cnt <= ssg_cnt + 2'd1;
            end
            third_cnt <= (third_cnt == 2'd2) ? 2'd0 : third_cnt + 2'd1;
        end
    end

    // adpcm chain 12 then 6 then 2
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt666 <= '0;
            cnt111 <= '0;
            cnt55  <= '0;
        end else if (cen) begin
            cnt666 <= (cnt666 == a666_cnt_t'(ADPCM_666_DIV - 1)) ? '0
                                                                   : cnt666 + a666_cnt_t'(1);
            if (cnt666 == '0) begin  // stage 2 steps once per 666k tick
                cnt111 <= (cnt111 == a111_cnt_t'(ADPCM_111_DIV - 1)) ? '0
                                                                       : cnt111 + a111_cnt_t'(1);
                if (cnt111 == '0) begin
                    cnt55 <= (cnt55 == a55_cnt_t'(ADPCM_55_DIV - 1)) ? '0
                                                                     : cnt55 + a55_cnt_t'(1);
                end
            end
        end
    end

    // zero flags and cen registered together
    always_ff @(posedge clk) begin
        if (rst) begin
            zero_q <= '0;
            cen_q  <= 1'b0;
        end else begin
            zero_q.fm    <= fm_cnt == '0;
            zero_q.third <= third_cnt == '0;
            zero_q.ssg   <= USE_SSG && (ssg_cnt == '0);  // held low without ssg
            zero_q.a666  <= cnt666 == '0;
            zero_q.a111  <= (cnt666 == '0) && (cnt111 == '0);  // nested so rates stay aligned
            zero_q.a55   <= (cnt666 == '0) && (cnt111 == '0) && (cnt55 == '0);
            cen_q        <= cen;
        end
    end

    // output pulses two clocks after the zero count
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_ens <= '0;
        end else begin
            clk_ens <= zero_q & {$bits(clk_ens_t){cen_q}};
        end
    end

endmodule

// File: hw/opn_timers.sv
`timescale 1ns/10ps

module opn_timers
    import opn_clk_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       fm_en,
    input  timer_cfg_t timer_cfg,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq
);

    smp_cnt_t smp_cnt;   // fm pulses within a sample
    tbp_cnt_t tbp_cnt;   // samples within a timer b step
    timer_a_t cnt_a;
    timer_b_t cnt_b;
    logic     smp_tick;
    logic     tick_b;
    logic     ovf_a;
    logic     ovf_b;

    assign smp_tick = fm_en && (smp_cnt == smp_cnt_t'(FM_PER_SAMPLE - 1));
    assign tick_b   = smp_tick && (tbp_cnt == tbp_cnt_t'(TB_PRESCALE - 1));
    // overflow when the counter sits at all ones on its tick
    assign ovf_a    = timer_cfg.load_a && smp_tick && (cnt_a == '1);
    assign ovf_b    = timer_cfg.load_b && tick_b && (cnt_b == '1);

    // sample and timer b prescale, free running
    always_ff @(posedge clk) begin
        if (rst) begin
            smp_cnt <= '0;
            tbp_cnt <= '0;
        end else if (fm_en) begin
            smp_cnt <= smp_tick ? '0 : smp_cnt + smp_cnt_t'(1);
            if (smp_tick) begin
                tbp_cnt <= tick_b ? '0 : tbp_cnt + tbp_cnt_t'(1);
            end
        end
    end

    // up counters, held at the load value while stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
            cnt_b <= '0;
        end else begin
            if (!timer_cfg.load_a) begin
                cnt_a <= timer_cfg.val_a;
            end else if (smp_tick) begin
                cnt_a <= ovf_a ? timer_cfg.val_a : cnt_a + 10'd1;  // period 1024 - val_a
            end
            if (!timer_cfg.load_b) begin
                cnt_b <= timer_cfg.val_b;
            end else if (tick_b) begin
                cnt_b <= ovf_b ? timer_cfg.val_b : cnt_b + 8'd1;   // period 256 - val_b
            end
        end
    end

    // flags, a fresh overflow beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            irq    <= 1'b0;
        end else begin
            if (ovf_a && timer_cfg.en_a) begin
                flag_a <= 1'b1;
            end else if (timer_cfg.rst_flag_a) begin
                flag_a <= 1'b0;
            end
            if (ovf_b && timer_cfg.en_b) begin
                flag_b <= 1'b1;
            end else if (timer_cfg.rst_flag_b) begin
                flag_b <= 1'b0;
            end
            irq <= flag_a | flag_b;  // one cycle behind the flags
        end
    end

endmodule

// File: hw/opn_clk_top.sv
`timescale 1ns/10ps

module opn_clk_top
    import opn_clk_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  cpu_wr_t  cpu_wr,
    output clk_ens_t clk_ens,
    output logic     flag_a,
    output logic     flag_b,
    output logic     irq
);

    div_sel_t   div_sel;    // prescaler select to the divider
    timer_cfg_t timer_cfg;  // timer setup from the register block

    // cpu register decode
    opn_reg_if opn_reg_if_i (
        .clk       (clk),
        .rst       (rst),
        .cpu_wr    (cpu_wr),
        .div_sel   (div_sel),
        .timer_cfg (timer_cfg)
    );

    // enable generation
    opn_clk_div opn_clk_div_i (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_ens (clk_ens)
    );

    // timers run off the fm enable
    opn_timers opn_timers_i (
        .clk       (clk),
        .rst       (rst),
        .fm_en     (clk_ens.fm),
        .timer_cfg (timer_cfg),
        .flag_a    (flag_a),
        .flag_b    (flag_b),
        .irq       (irq)
    );

endmodule

// File: dv/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset over 8 rising edges, dropped on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: dv/opn_clk_sva.sv
`timescale 1ns/10ps

module opn_clk_sva
    import opn_clk_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     cen,
    input clk_ens_t clk_ens,
    input logic     flag_a,
    input logic     flag_b,
    input logic     irq
);

    // ssg left out since the 1/1 setting keeps it high every cen cycle
    one_shot: assert property (@(posedge clk) disable iff (rst)
        (clk_ens & $past(clk_ens) & 6'b110111) == '0)
        else $error("enable held high for more than one cycle");

    // slower adpcm rates sit on top of the faster ones
    a55_in_a111: assert property (@(posedge clk) disable iff (rst)
        clk_ens.a55 |-> clk_ens.a111)
        else $error("a55 pulse without a111 pulse");
    a111_in_a666: assert property (@(posedge clk) disable iff (rst)
        clk_ens.a111 |-> clk_ens.a666)
        else $error("a111 pulse without a666 pulse");

    // first cycle out of reset still sees the cleared pipe
    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |=> clk_ens == '0)
        else $error("enable pulse in the cycle after reset");

    // pulse needs cen two clocks earlier
    cen_behind: assert property (@(posedge clk) disable iff (rst)
        (|clk_ens) |-> $past(cen, 2))
        else $error("enable pulse without cen");

    irq_follow: assert property (@(posedge clk) disable iff (rst)
        irq == $past(flag_a | flag_b))
        else $error("irq does not follow the flags");

endmodule

// divider side with the timer ports tied off
bind opn_clk_div opn_clk_sva div_sva_i (
    .clk     (clk),
    .rst     (rst),
    .cen     (cen),
    .clk_ens (clk_ens),
    .flag_a  (1'b0),
    .flag_b  (1'b0),
    .irq     (1'b0)
);

// timer side has no enables
bind opn_timers opn_clk_sva tmr_sva_i (
    .clk     (clk),
    .rst     (rst),
    .cen     (1'b0),
    .clk_ens ('0),
    .flag_a  (flag_a),
    .flag_b  (flag_b),
    .irq     (irq)
);

// File: dv/opn_clk_tb.sv
`timescale 1ns/10ps

module opn_clk_tb
    import opn_clk_pkg::*;
();

    typedef enum logic [1:0] {CEN_LOW, CEN_HIGH, CEN_RAND} cen_mode_t;

    typedef struct {
        string            name;
        int               nwr;     // number of prescaler writes up to 2
        reg_addr_t        wa0;
        reg_addr_t        wa1;
        cen_mode_t        mode;
        int               window;  // cycles counted
        logic [5:0][7:0]  div;     // expected divisor in clk_ens bit order
    } row_t;

    logic     clk;
    logic     rst;
    logic     cen;
    cpu_wr_t  cpu_wr;
    clk_ens_t clk_ens;
    logic     flag_a;
    logic     flag_b;
    logic     irq;

    row_t  rows[$];
    string en_name [6] = '{"a55", "a111", "a666", "ssg", "third", "fm"};
    int    en_cnt [6];
    int    cen_cnt;
    int    errors;
    int    timeouts;
    logic  d1;  // cen driven one cycle back
    logic  d2;  // two cycles back

    tb_clkgen tb_clkgen_i (
        .clk (clk),
        .rst (rst)
    );

    opn_clk_top opn_clk_top_i (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .cpu_wr  (cpu_wr),
        .clk_ens (clk_ens),
        .flag_a  (flag_a),
        .flag_b  (flag_b),
        .irq     (irq)
    );

    task automatic add_row(input string name, input int nwr, input reg_addr_t wa0,
                           input reg_addr_t wa1, input cen_mode_t mode, input int window,
                           input logic [5:0][7:0] div);
        row_t r;
        r.name   = name;
        r.nwr    = nwr;
        r.wa0    = wa0;
        r.wa1    = wa1;
        r.mode   = mode;
        r.window = window;
        r.div    = div;
        rows.push_back(r);
    endtask

    // one cycle write strobe
    task automatic cpu_write(input reg_addr_t addr, input reg_data_t data);
        @(negedge clk);
        cpu_wr.wr   = 1'b1;
        cpu_wr.addr = addr;
        cpu_wr.data = data;
        @(negedge clk);
        cpu_wr.wr = 1'b0;
    endtask

    task automatic check_range(input string test, input string what, input int lo,
                               input int hi, input int actual);
        assert (actual >= lo && actual <= hi) else begin
            errors++;
            $display("[FAIL] %s %s: expected %0d to %0d actual %0d", test, what, lo, hi, actual);
        end
    endtask

    // sample enables then drive cen for the next edge
    task automatic run_cycles(input int n, input cen_mode_t mode);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            for (int b = 0; b < 6; b++) en_cnt[b] += int'(clk_ens[b]);
            assert (d2 || clk_ens == '0) else begin
                errors++;
                $display("enable pulse although cen was low two cycles earlier, at %0t", $time);
            end
            case (mode)
                CEN_LOW:  cen = 1'b0;
                CEN_HIGH: cen = 1'b1;
                default:  cen = 1'($urandom & 1);
            endcase
            cen_cnt += int'(cen);
            d2 = d1;
            d1 = cen;
        end
    endtask

    // sel 0 flag_a, 1 flag_b, 2 irq
    task automatic wait_for(input string what, input int sel, input logic level,
                            input int limit, output int fm_seen);
        logic val;
        fm_seen = 0;
        for (int i = 0; i < limit; i++) begin
            @(negedge clk);
            val = (sel == 0) ? flag_a : (sel == 1) ? flag_b : irq;
            if (val == level) return;
            fm_seen += int'(clk_ens.fm);  // fm pulses before the change
        end
        timeouts++;
        $display("timeout: %s did not reach %0b within %0d cycles", what, level, limit);
    endtask

    initial begin
        int fm_seen;
        int hits;
        cen      = 1'b0;
        cpu_wr   = '0;
        d1       = 1'b0;
        d2       = 1'b0;
        errors   = 0;
        timeouts = 0;
        cen_cnt  = 0;
        void'($urandom(99));

        //      name              writes  addr   addr   cen       window  fm  3rd ssg 666 111 55
        add_row("reset_defaults", 0, 8'h00, 8'h00, CEN_HIGH, 1440,
                {8'd6, 8'd3, 8'd4, 8'd12, 8'd72, 8'd144});
        add_row("write_2d_2e",    2, ADDR_PRES_2D, ADDR_PRES_2E, CEN_HIGH, 1440,
                {8'd3, 8'd3, 8'd2, 8'd12, 8'd72, 8'd144});
        add_row("write_2f",       1, ADDR_PRES_2F, 8'h00, CEN_HIGH, 1440,
                {8'd2, 8'd3, 8'd1, 8'd12, 8'd72, 8'd144});
        add_row("write_2d_again", 1, ADDR_PRES_2D, 8'h00, CEN_HIGH, 1440,
                {8'd6, 8'd3, 8'd4, 8'd12, 8'd72, 8'd144});
        add_row("random_cen",     0, 8'h00, 8'h00, CEN_RAND, 2880,
                {8'd6, 8'd3, 8'd4, 8'd12, 8'd72, 8'd144});

        for (int i = 0; i < 20 && rst; i++) @(negedge clk);
        if (rst) begin
            timeouts++;
            $display("timeout: reset was never released");
        end

        foreach (rows[r]) begin
            if (rows[r].nwr > 0) cpu_write(rows[r].wa0, 8'h00);  // data is ignored
            if (rows[r].nwr > 1) cpu_write(rows[r].wa1, 8'h00);
            run_cycles(16, CEN_HIGH);  // new select waits for a wrap
            run_cycles(4, CEN_LOW);    // drain the two stage pipe
            foreach (en_cnt[b]) en_cnt[b] = 0;
            cen_cnt = 0;
            run_cycles(rows[r].window, rows[r].mode);
            run_cycles(4, CEN_LOW);    // late pulses of the window
            for (int b = 0; b < 6; b++) begin
                check_range(rows[r].name, en_name[b], cen_cnt / int'(rows[r].div[b]) - 1,
                            cen_cnt / int'(rows[r].div[b]) + 1, en_cnt[b]);
            end
        end

        // timer a at 1020 overflows every 4 sample ticks
        cen = 1'b1;
        cpu_write(ADDR_TA_HI, 8'hff);
        cpu_write(ADDR_TA_LO, 8'h00);
        cpu_write(ADDR_TCTL, 8'h05);  // load_a and en_a
        wait_for("flag_a", 0, 1'b1, 1000, fm_seen);
        check_range("timer_a", "fm pulses to flag_a", 3 * FM_PER_SAMPLE, 100, fm_seen);
        wait_for("irq", 2, 1'b1, 4, fm_seen);
        cpu_write(ADDR_TCTL, 8'h10);  // stop and clear flag a
        wait_for("flag_a", 0, 1'b0, 4, fm_seen);
        wait_for("irq", 2, 1'b0, 4, fm_seen);

        // timer b at 254 needs two steps of 16 samples
        cpu_write(ADDR_TB, 8'hfe);
        cpu_write(ADDR_TCTL, 8'h0b);  // both timers run with en_a low
        wait_for("flag_b", 1, 1'b1, 6000, fm_seen);
        check_range("timer_b", "fm pulses to flag_b", 383, 772, fm_seen);
        check_range("timer_b", "flag_a", 0, 0, int'(flag_a));
        cpu_write(ADDR_TCTL, 8'h20);
        wait_for("flag_b", 1, 1'b0, 4, fm_seen);
        cpu_write(ADDR_TCTL, 8'h02);  // runs with en_b low
        hits = 0;
        for (int i = 0; i < 5000; i++) begin
            @(negedge clk);
            hits += int'(flag_b | irq);
        end
        check_range("timer_b_masked", "cycles with flag_b or irq", 0, 0, hits);

        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: build.f
hw/opn_clk_pkg.sv
hw/opn_reg_if.sv
hw/opn_clk_div.sv
hw/opn_timers.sv
hw/opn_clk_top.sv
dv/tb_clkgen.sv
dv/opn_clk_sva.sv
dv/opn_clk_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := opn_clk_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
